//--- include/bridge_consts.svh
// bridge constants
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// bursts in flight
`define BR_SLOTS 2
`define BR_ID_W 2
`define BR_ADDR_W 12
`define BR_DATA_W 32

// lite response buffer entries
`define BR_BUF_DEPTH 2

`endif

//--- hw/bridge_pkg.sv
// bridge types
`include "bridge_consts.svh"

package bridge_pkg;

   typedef logic [$clog2(`BR_SLOTS)-1:0] slot_idx_t;
   typedef logic [`BR_ID_W-1:0]          burst_id_t;
   typedef logic [`BR_ADDR_W-1:0]        addr_t;   // byte address
   typedef logic [`BR_DATA_W-1:0]        data_t;
   typedef logic [7:0]                   beat_cnt_t; // beats left minus one

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_e;

   // SLOT_LAST means the next beat closes the burst
   typedef enum logic [1:0] {
      SLOT_FREE = 2'b00,
      SLOT_BUSY = 2'b01,
      SLOT_LAST = 2'b10
   } slot_state_e;

endpackage

//--- hw/slot_if.sv
// slot allocation and release
`timescale 1ns/1ns

interface slot_if;
   import bridge_pkg::*;

   logic      alloc;       // one cycle pulse
   slot_idx_t alloc_slot;
   burst_id_t alloc_id;
   addr_t     alloc_addr;
   beat_cnt_t alloc_len;

   logic      free;        // one cycle pulse
   slot_idx_t free_slot;

   // decode side
   modport alloc_drv (
      output alloc, alloc_slot, alloc_id, alloc_addr, alloc_len,
      input  free, free_slot
   );

   // issue and collect side
   modport alloc_rcv (
      input  alloc, alloc_slot, alloc_id, alloc_addr, alloc_len,
      output free, free_slot
   );
endinterface

//--- hw/arb_rr.sv
// round robin arbiter
`timescale 1ns/1ns

module arb_rr #(
   parameter int n = 2
) (
   input  logic         clk,
   input  logic         rstn,
   input  logic [n-1:0] req,
   output logic [n-1:0] gnt,
   input  logic         hold
);
   localparam int pw = (n > 1) ? $clog2(n) : 1;

   logic [pw-1:0] last_q, win;
   logic [n-1:0]  gnt_new, gnt_q;
   logic          found;

   // first request after the previous winner
   always_comb begin
      gnt_new = '0;
      win     = last_q;
      found   = 1'b0;
      for (int k = 1; k <= n; k++) begin
         if (!found && req[(int'(last_q) + k) % n]) begin
            found = 1'b1;
            win   = pw'((int'(last_q) + k) % n);
         end
      end
      gnt_new[win] = found;
   end

   assign gnt = hold ? gnt_q : gnt_new;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         last_q <= pw'(n - 1);   // slot 0 wins first
         gnt_q  <= '0;
      end else begin
         gnt_q <= gnt;
         if (!hold && found)
            last_q <= win;
      end
   end
endmodule

//--- hw/read_decode.sv
// burst accept and slot allocation
`timescale 1ns/1ns
`include "bridge_consts.svh"

module read_decode (
   input  logic                  clk,
   input  logic                  rstn,
   input  bridge_pkg::burst_id_t ar_id,
   input  bridge_pkg::beat_cnt_t ar_len,
   input  bridge_pkg::addr_t     ar_addr,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   slot_if.alloc_drv             slot
);
   import bridge_pkg::*;

   slot_state_e          state_q [`BR_SLOTS];
   burst_id_t            id_q    [`BR_SLOTS];
   logic [`BR_SLOTS-1:0] free_vec, conflict_vec;
   slot_idx_t            avail_idx;
   logic                 ar_hs;

   // lowest free slot wins
   always_comb begin
      avail_idx = '0;
      for (int s = `BR_SLOTS - 1; s >= 0; s--) begin
         free_vec[s]     = state_q[s] == SLOT_FREE;
         conflict_vec[s] = !free_vec[s] && id_q[s] == ar_id;
         if (free_vec[s])
            avail_idx = slot_idx_t'(s);
      end
   end

   assign ar_ready = |free_vec && !(|conflict_vec);
   assign ar_hs    = ar_valid && ar_ready;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         for (int s = 0; s < `BR_SLOTS; s++)
            state_q[s] <= SLOT_FREE;
         slot.alloc <= 1'b0;
      end else begin
         slot.alloc <= ar_hs;
         if (slot.free)
            state_q[slot.free_slot] <= SLOT_FREE;
         if (ar_hs)
            state_q[avail_idx] <= SLOT_BUSY;   // busy now, so ar_ready drops at once
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         id_q[avail_idx] <= ar_id;
         slot.alloc_slot <= avail_idx;
         slot.alloc_id   <= ar_id;
         slot.alloc_addr <= ar_addr;
         slot.alloc_len  <= ar_len;
      end
   end

   // releases only hit slots in use
   a_free_busy_slot: assert property (@(posedge clk) disable iff (!rstn)
      slot.free |-> state_q[slot.free_slot] != SLOT_FREE);
endmodule

//--- hw/read_issue.sv
// lite read issue
`timescale 1ns/1ns
`include "bridge_consts.svh"

module read_issue (
   input  logic                  clk,
   input  logic                  rstn,
   slot_if.alloc_rcv             slot,
   output bridge_pkg::burst_id_t lite_ar_id,
   output bridge_pkg::addr_t     lite_ar_addr,
   output logic                  lite_ar_valid,
   input  logic                  lite_ar_ready
);
   import bridge_pkg::*;

   burst_id_t            id_q   [`BR_SLOTS];
   addr_t                addr_q [`BR_SLOTS];   // next address to read
   beat_cnt_t            cnt_q  [`BR_SLOTS];   // reads left minus one
   logic [`BR_SLOTS-1:0] pend_q, gnt;
   logic                 stall_q;
   slot_idx_t            gnt_idx;
   logic                 ar_hs;

   arb_rr #(
      .n (`BR_SLOTS)
   ) u_arb (
      .clk  (clk),
      .rstn (rstn),
      .req  (pend_q),
      .gnt  (gnt),
      .hold (stall_q)
   );

   always_comb begin
      gnt_idx = '0;
      for (int s = 0; s < `BR_SLOTS; s++)
         if (gnt[s])
            gnt_idx = slot_idx_t'(s);
   end

   assign lite_ar_valid = |gnt;
   assign lite_ar_id    = id_q[gnt_idx];
   assign lite_ar_addr  = addr_q[gnt_idx];
   assign ar_hs         = lite_ar_valid && lite_ar_ready;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         pend_q  <= '0;
         stall_q <= 1'b0;
      end else begin
         stall_q <= lite_ar_valid && !lite_ar_ready;   // freezes the grant next cycle
         if (ar_hs && cnt_q[gnt_idx] == '0)
            pend_q[gnt_idx] <= 1'b0;
         if (slot.alloc)
            pend_q[slot.alloc_slot] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         addr_q[gnt_idx] <= addr_q[gnt_idx] + addr_t'(4);
         if (cnt_q[gnt_idx] != '0)
            cnt_q[gnt_idx] <= cnt_q[gnt_idx] - beat_cnt_t'(1);
      end
      if (slot.alloc) begin
         id_q[slot.alloc_slot]   <= slot.alloc_id;
         addr_q[slot.alloc_slot] <= slot.alloc_addr;
         cnt_q[slot.alloc_slot]  <= slot.alloc_len;
      end
   end

   a_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
      lite_ar_valid && !lite_ar_ready |=>
         lite_ar_valid && $stable(lite_ar_addr) && $stable(lite_ar_id));
endmodule

//--- hw/read_collect.sv
// lite response collect and burst beat output
`timescale 1ns/1ns
`include "bridge_consts.svh"

module read_collect (
   input  logic                  clk,
   input  logic                  rstn,
   slot_if.alloc_rcv             slot,
   input  bridge_pkg::burst_id_t lite_r_id,
   input  bridge_pkg::data_t     lite_r_data,
   input  bridge_pkg::resp_e     lite_r_resp,
   input  logic                  lite_r_valid,
   output logic                  lite_r_ready,
   output bridge_pkg::burst_id_t r_id,
   output bridge_pkg::data_t     r_data,
   output bridge_pkg::resp_e     r_resp,
   output logic                  r_last,
   output logic                  r_valid,
   input  logic                  r_ready
);
   import bridge_pkg::*;

   localparam int ptr_w = (`BR_BUF_DEPTH > 1) ? $clog2(`BR_BUF_DEPTH) : 1;

   burst_id_t                id_buf   [`BR_BUF_DEPTH];
   data_t                    data_buf [`BR_BUF_DEPTH];
   resp_e                    resp_buf [`BR_BUF_DEPTH];
   logic [`BR_BUF_DEPTH-1:0] buf_vld;
   logic [ptr_w-1:0]         rp, wp;

   slot_state_e          state_q [`BR_SLOTS];
   burst_id_t            id_q    [`BR_SLOTS];
   beat_cnt_t            cnt_q   [`BR_SLOTS];
   logic [`BR_SLOTS-1:0] match_vec;
   slot_idx_t            match_idx;
   logic                 r_hs;

   function automatic logic [ptr_w-1:0] ptr_incr(input logic [ptr_w-1:0] p);
      if (int'(p) == `BR_BUF_DEPTH - 1)
         return '0;
      return p + ptr_w'(1);
   endfunction

   // head entry against the live slots
   always_comb begin
      match_idx = '0;
      for (int s = 0; s < `BR_SLOTS; s++) begin
         match_vec[s] = buf_vld[rp] && state_q[s] != SLOT_FREE && id_q[s] == id_buf[rp];
         if (match_vec[s])
            match_idx = slot_idx_t'(s);
      end
   end

   assign lite_r_ready   = !buf_vld[wp];
   assign r_valid        = |match_vec;
   assign r_id           = id_buf[rp];
   assign r_data         = data_buf[rp];
   assign r_resp         = resp_buf[rp];
   assign r_last         = state_q[match_idx] == SLOT_LAST;
   assign r_hs           = r_valid && r_ready;
   assign slot.free      = r_hs && r_last;
   assign slot.free_slot = match_idx;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         buf_vld <= '0;
         rp      <= '0;
         wp      <= '0;
         for (int s = 0; s < `BR_SLOTS; s++)
            state_q[s] <= SLOT_FREE;
      end else begin
         if (lite_r_valid && lite_r_ready) begin
            buf_vld[wp] <= 1'b1;
            wp          <= ptr_incr(wp);
         end
         if (r_hs) begin
            buf_vld[rp] <= 1'b0;
            rp          <= ptr_incr(rp);
            if (r_last)
               state_q[match_idx] <= SLOT_FREE;
            else if (cnt_q[match_idx] == beat_cnt_t'(1))
               state_q[match_idx] <= SLOT_LAST;
         end
         if (slot.alloc)
            state_q[slot.alloc_slot] <= (slot.alloc_len == '0) ? SLOT_LAST : SLOT_BUSY;
      end
   end

   always_ff @(posedge clk) begin
      if (lite_r_valid && lite_r_ready) begin
         id_buf[wp]   <= lite_r_id;
         data_buf[wp] <= lite_r_data;
         resp_buf[wp] <= lite_r_resp;
      end
      if (r_hs && !r_last)
         cnt_q[match_idx] <= cnt_q[match_idx] - beat_cnt_t'(1);
      if (slot.alloc) begin
         id_q[slot.alloc_slot]  <= slot.alloc_id;
         cnt_q[slot.alloc_slot] <= slot.alloc_len;
      end
   end

   // every buffered response belongs to exactly one live burst
   a_head_match: assert property (@(posedge clk) disable iff (!rstn)
      buf_vld[rp] |-> $onehot(match_vec));
endmodule

//--- hw/burst_read_bridge.sv
// burst to lite read bridge
`timescale 1ns/1ns

module burst_read_bridge (
   input  logic                  clk,
   input  logic                  rstn,
   // burst request
   input  bridge_pkg::burst_id_t ar_id,
   input  bridge_pkg::addr_t     ar_addr,
   input  bridge_pkg::beat_cnt_t ar_len,
   input  logic                  ar_valid,
   output logic                  ar_ready,
   // burst data
   output bridge_pkg::burst_id_t r_id,
   output bridge_pkg::data_t     r_data,
   output bridge_pkg::resp_e     r_resp,
   output logic                  r_last,
   output logic                  r_valid,
   input  logic                  r_ready,
   // lite read address
   output bridge_pkg::burst_id_t lite_ar_id,
   output bridge_pkg::addr_t     lite_ar_addr,
   output logic                  lite_ar_valid,
   input  logic                  lite_ar_ready,
   // lite read data
   input  bridge_pkg::burst_id_t lite_r_id,
   input  bridge_pkg::data_t     lite_r_data,
   input  bridge_pkg::resp_e     lite_r_resp,
   input  logic                  lite_r_valid,
   output logic                  lite_r_ready
);
   slot_if u_slot ();

   read_decode u_decode (
      .clk      (clk),
      .rstn     (rstn),
      .ar_id    (ar_id),
      .ar_len   (ar_len),
      .ar_addr  (ar_addr),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .slot     (u_slot.alloc_drv)
   );

   read_issue u_issue (
      .clk           (clk),
      .rstn          (rstn),
      .slot          (u_slot.alloc_rcv),
      .lite_ar_id    (lite_ar_id),
      .lite_ar_addr  (lite_ar_addr),
      .lite_ar_valid (lite_ar_valid),
      .lite_ar_ready (lite_ar_ready)
   );

   read_collect u_collect (
      .clk          (clk),
      .rstn         (rstn),
      .slot         (u_slot.alloc_rcv),
      .lite_r_id    (lite_r_id),
      .lite_r_data  (lite_r_data),
      .lite_r_resp  (lite_r_resp),
      .lite_r_valid (lite_r_valid),
      .lite_r_ready (lite_r_ready),
      .r_id         (r_id),
      .r_data       (r_data),
      .r_resp       (r_resp),
      .r_last       (r_last),
      .r_valid      (r_valid),
      .r_ready      (r_ready)
   );
endmodule

//--- testbench/tb_bridge.sv
// burst read bridge testbench
`timescale 1ns/1ns

module tb_bridge;
   import bridge_pkg::*;

   localparam int max_ent = 256;
   localparam int vec_words = 240;
   localparam int ar_limit = 1000;    // cycles
   localparam int drain_limit = 4000;

   logic clk = 1'b0;
   logic rstn;
   burst_id_t ar_id, r_id, lite_ar_id, lite_r_id;
   addr_t ar_addr, lite_ar_addr;
   beat_cnt_t ar_len;
   logic ar_valid, ar_ready, r_last, r_valid, r_ready;
   data_t r_data, lite_r_data;
   resp_e r_resp, lite_r_resp;
   logic lite_ar_valid, lite_ar_ready, lite_r_valid, lite_r_ready;

   logic [31:0] vec_mem [vec_words];
   burst_id_t ent_id [max_ent];     // one entry per expected beat
   addr_t ent_addr [max_ent];
   logic ent_last [max_ent];
   logic beat_done [max_ent];
   logic issue_done [max_ent];
   int n_ent, beats_done, mon_errors, seq_errors, rr_pct, lar_pct, cycle;
   logic timed_out;
   string cur_test;

   burst_read_bridge uut (.*);

   always #4 clk = ~clk;

   function automatic data_t expected_data(input addr_t a);
      return data_t'(a) * 32'd3 + 32'h1000_0001;
   endfunction

   function automatic resp_e expected_resp(input addr_t a);
      return a[11] ? SLVERR : OKAY;
   endfunction

   function automatic string test_name(input logic [31:0] t);
      case (t)
         32'd1: return "single_burst";
         32'd2: return "resp_pass";
         32'd3: return "interleave";
         32'd4: return "id_conflict";
         32'd5: return "back_pressure";
         default: return "unknown";
      endcase
   endfunction

   // oldest pending entry for an id or -1
   function automatic int find_beat(input burst_id_t id, input logic issue);
      for (int k = 0; k < n_ent; k++) begin
         if (ent_id[k] == id && !(issue ? issue_done[k] : beat_done[k]))
            return k;
      end
      return -1;
   endfunction

   function automatic logic id_live(input burst_id_t id);
      return find_beat(id, 1'b0) >= 0;
   endfunction

   task automatic value_mismatch(input string what, input logic [31:0] exp, act);
      $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
      mon_errors++;
   endtask

   task automatic protocol_error(input string msg);
      $display("%s: %s", cur_test, msg);
      mon_errors++;
   endtask

   // lite slave model plus r_ready source and monitor
   initial begin
      addr_t a;
      int k;
      logic r_stall, lr_hs;
      burst_id_t held_id;
      data_t held_data;
      resp_e held_resp;
      logic held_last;
      addr_t slv_addr_q [$];
      burst_id_t slv_id_q [$];
      int slv_due_q [$];
      void'($urandom(32'hce18_9055));
      r_ready = 1'b0;
      lite_ar_ready = 1'b0;
      lite_r_valid = 1'b0;
      lite_r_id = '0;
      lite_r_data = '0;
      lite_r_resp = OKAY;
      r_stall = 1'b0;
      lr_hs = 1'b0;
      cycle = 0;
      mon_errors = 0;
      beats_done = 0;
      for (int i = 0; i < max_ent; i++) begin
         beat_done[i] = 1'b0;
         issue_done[i] = 1'b0;
      end
      forever begin
         @(negedge clk);
         if (rstn) begin
            if (lite_ar_valid && lite_ar_ready) begin
               k = find_beat(lite_ar_id, 1'b1);
               assert (k >= 0) else protocol_error("lite read for an id with no live burst");
               if (k >= 0) begin
                  assert (lite_ar_addr == ent_addr[k]) else
                     value_mismatch("lite_ar_addr", 32'(ent_addr[k]), 32'(lite_ar_addr));
                  issue_done[k] = 1'b1;
               end
               slv_addr_q.push_back(lite_ar_addr);
               slv_id_q.push_back(lite_ar_id);
               slv_due_q.push_back(cycle + 1 + int'($urandom % 4));
            end
            if (r_stall) begin
               assert (r_valid && r_id == held_id && r_data == held_data &&
                       r_resp == held_resp && r_last == held_last) else
                  protocol_error("r beat changed or dropped while stalled");
            end
            if (r_valid && r_ready) begin
               k = find_beat(r_id, 1'b0);
               assert (k >= 0) else protocol_error("r beat arrived that no burst expects");
               if (k >= 0) begin
                  assert (r_data == expected_data(ent_addr[k])) else
                     value_mismatch("r_data", expected_data(ent_addr[k]), r_data);
                  assert (r_resp == expected_resp(ent_addr[k])) else
                     value_mismatch("r_resp", 32'(expected_resp(ent_addr[k])), 32'(r_resp));
                  assert (r_last == ent_last[k]) else
                     value_mismatch("r_last", 32'(ent_last[k]), 32'(r_last));
                  beat_done[k] = 1'b1;
                  beats_done++;
               end
            end
            r_stall = r_valid && !r_ready;
            held_id = r_id;
            held_data = r_data;
            held_resp = r_resp;
            held_last = r_last;
            lr_hs = lite_r_valid && lite_r_ready;
         end
         @(posedge clk);
         #1;
         cycle++;
         r_ready = ($urandom % 100) < rr_pct;
         lite_ar_ready = ($urandom % 100) < lar_pct;
         if (lite_r_valid && lr_hs)
            lite_r_valid = 1'b0;
         if (!lite_r_valid && slv_due_q.size() > 0 && slv_due_q[0] <= cycle) begin
            a = slv_addr_q.pop_front();
            lite_r_id = slv_id_q.pop_front();
            void'(slv_due_q.pop_front());
            lite_r_data = expected_data(a);
            lite_r_resp = expected_resp(a);
            lite_r_valid = 1'b1;
         end
      end
   end

   task automatic issue_burst(input int v);
      int wait_cnt;
      logic accepted;
      burst_id_t id;
      addr_t addr;
      beat_cnt_t len;
      id = burst_id_t'(vec_mem[v*6+1]);
      addr = addr_t'(vec_mem[v*6+2]);
      len = beat_cnt_t'(vec_mem[v*6+3]);
      rr_pct = int'(vec_mem[v*6+4]);
      lar_pct = int'(vec_mem[v*6+5]);
      @(posedge clk);
      #1;
      ar_valid = 1'b1;
      ar_id = id;
      ar_addr = addr;
      ar_len = len;
      wait_cnt = 0;
      accepted = 1'b0;
      while (!accepted && !timed_out) begin
         @(negedge clk);
         if (id_live(id)) begin   // same id still in flight
            assert (!ar_ready) else begin
               $display("ERROR %s: ar_ready expected 0 actual 1 for live id %0d", cur_test, id);
               seq_errors++;
            end
         end
         if (ar_ready) begin
            accepted = 1'b1;
            for (int b = 0; b <= int'(len); b++) begin
               ent_id[n_ent] = id;
               ent_addr[n_ent] = addr + addr_t'(4 * b);
               ent_last[n_ent] = b == int'(len);
               n_ent++;
            end
         end else begin
            wait_cnt++;
            if (wait_cnt > ar_limit) begin
               $display("%s: burst %0d was never accepted", cur_test, v);
               seq_errors++;
               timed_out = 1'b1;
            end
         end
      end
      @(posedge clk);
      #1;
      ar_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int wait_cnt;
      wait_cnt = 0;
      while (!timed_out && beats_done < n_ent) begin
         @(negedge clk);
         wait_cnt++;
         if (wait_cnt > drain_limit) begin
            $display("%s: %0d beats never came back", cur_test, n_ent - beats_done);
            seq_errors++;
            timed_out = 1'b1;
         end
      end
   endtask

   initial begin
      int v;
      logic [31:0] t;
      rstn = 1'b0;
      ar_valid = 1'b0;
      ar_id = '0;
      ar_addr = '0;
      ar_len = '0;
      rr_pct = 100;
      lar_pct = 100;
      n_ent = 0;
      seq_errors = 0;
      timed_out = 1'b0;
      cur_test = "reset_state";
      for (int i = 0; i < vec_words; i++)
         vec_mem[i] = 32'hffff_ffff;   // end marker
      $readmemh("testbench/bridge_vectors.txt", vec_mem);
      repeat (10) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(negedge clk);
      assert (!r_valid && !lite_ar_valid && ar_ready && lite_r_ready) else begin
         $display("ERROR %s: %s expected 0011 actual %b%b%b%b", cur_test,
                  "r_valid/lite_ar_valid/ar_ready/lite_r_ready",
                  r_valid, lite_ar_valid, ar_ready, lite_r_ready);
         seq_errors++;
      end
      v = 0;
      while (!timed_out && vec_mem[v*6] != 32'hffff_ffff) begin
         t = vec_mem[v*6];
         cur_test = test_name(t);
         while (!timed_out && vec_mem[v*6] == t) begin
            issue_burst(v);
            v++;
         end
         wait_drain();
      end
      $display("closing: beats %0d, monitor errors %0d, sequence errors %0d",
               beats_done, mon_errors, seq_errors);
      if (mon_errors + seq_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end
endmodule

//--- build.f
+incdir+include
hw/bridge_pkg.sv
hw/slot_if.sv
hw/arb_rr.sv
hw/read_decode.sv
hw/read_issue.sv
hw/read_collect.sv
hw/burst_read_bridge.sv
testbench/tb_bridge.sv

//--- Makefile
# Verilator build and run for the burst read bridge

VERILATOR ?= verilator
TOP       ?= tb_bridge
RTL_TOP   ?= burst_read_bridge
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/bridge_vectors.txt
// burst read vectors, every field in hex
// columns: test  id  addr  len  r_ready_pct  lite_ar_ready_pct
// tests: 1 single_burst, 2 resp_pass, 3 interleave, 4 id_conflict, 5 back_pressure
// a percentage of 64 means ready on every cycle

// single_burst
1 0 010 03 64 64

// resp_pass, crosses into the upper half at 800
2 1 7f0 07 64 64

// interleave, third burst waits for a free slot
3 0 100 05 64 64
3 2 300 05 64 64
3 3 040 02 64 64

// id_conflict, second burst reuses id 1
4 1 200 03 64 64
4 1 240 01 64 64

// back_pressure, r_ready 30 and lite_ar_ready 50 percent
5 0 400 07 1e 32
5 1 900 04 1e 32
5 2 600 00 1e 32
5 0 a00 02 1e 32
5 3 ff0 03 1e 32
5 2 7f8 03 1e 32
5 1 0c0 05 1e 32
